// ==== bench/key_panel_golden.txt ====
// mode key hold led abcdefgh hgfedcba, all hex, outputs after 40 released cycles
// mode 0 is a held press, 1 is a bounce burst, ff ends the list
0 01 30 01 fc 3f
0 04 30 05 da 5b
0 80 30 85 e0 07
// same key again, led off and digit kept
0 80 30 05 e0 07
// two keys at once, lower one shown
0 28 30 2d f2 4f
// bursts shorter than the debounce window
1 10 50 2d f2 4f
1 42 50 2d f2 4f
0 40 30 6d be 7d
0 02 30 6f 60 06
0 10 30 7f 66 66
0 20 30 5f b6 6d
0 28 30 77 f2 4f
ff 00 00 00 00 00

// ==== key_panel_top.f ====
common/board_pkg.sv
common/key_bus_if.sv
verilog/key_sampler.sv
verilog/key_debouncer.sv
verilog/key_panel_encoder.sv
verilog/key_panel_top.sv
bench/clock_gen.sv
bench/tb_key_panel.sv

// ==== Makefile ====
TOP = tb_key_panel

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f key_panel_top.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== bench/tb_key_panel.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_key_panel import board_pkg::*; ();

    localparam int max_steps     = 32;
    localparam int step_words    = 6;
    localparam int press_limit   = 40;
    localparam int settle_cycles = 40;
    localparam int on_run_max    = strobe_div * (stable_samples - 1);

    logic                clk;
    logic                reset;
    logic [n_keys - 1:0] key;
    logic [n_keys - 1:0] led;
    logic [         7:0] abcdefgh;
    logic [         7:0] hgfedcba;

    // mode, key pattern, hold, led, abcdefgh, hgfedcba per step
    logic [31:0] golden [0:max_steps * step_words - 1];
    integer      seed;

    clock_gen clock0 (.clk (clk));

    key_panel_top dut0
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .key      ( key      ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .hgfedcba ( hgfedcba )
    );

    //----------------------------------------
    // helpers

    function automatic logic [7:0] reverse_bits (input logic [7:0] value);
        logic [7:0] result;

        for (int i = 0; i < 8; i ++)
            result [i] = value [7 - i];

        return result;
    endfunction

    task automatic stop_with_error (input string reason);
        $display ("%s", reason);
        $display ("sim failed");
        $fatal (1);
    endtask

    task automatic check_value (input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected)
        begin
            $display ("CHECK FAILED at %0t ns: %s is %h, expected %h",
                      $time, what, actual, expected);
            $display ("sim failed");
            $fatal (1);
        end
    endtask

    task automatic check_outputs (input logic [31:0] exp_led, input logic [31:0] exp_abc,
                                  input logic [31:0] exp_hgf, input int step);
        check_value (32' (led),      exp_led, $sformatf ("led after step %0d", step));
        check_value (32' (abcdefgh), exp_abc, $sformatf ("abcdefgh after step %0d", step));
        check_value (32' (hgfedcba), exp_hgf, $sformatf ("hgfedcba after step %0d", step));
        check_value (32' (hgfedcba), 32' (reverse_bits (exp_abc [7:0])),
                     $sformatf ("mirror of abcdefgh after step %0d", step));
    endtask

    //----------------------------------------
    // stimulus steps, all driven on the falling edge

    task automatic hold_press (input logic [n_keys - 1:0] pattern, input int hold, input int step);
        logic [n_keys - 1:0] prev_led;
        int                  waited;

        prev_led = led;
        waited   = 0;
        key      = ~ pattern;

        while (led === prev_led)
        begin
            if (waited == press_limit)
                stop_with_error ($sformatf ("led did not react to the press of step %0d", step));
            @ (negedge clk);
            waited ++;
        end

        for (int i = waited; i < hold; i ++)
            @ (negedge clk);

        // key still held, so the point must be lit in both orders
        check_value (32' (abcdefgh [0]), 32'd1, $sformatf ("point in abcdefgh, step %0d", step));
        check_value (32' (hgfedcba [7]), 32'd1, $sformatf ("point in hgfedcba, step %0d", step));
    endtask

    task automatic bounce_keys (input logic [n_keys - 1:0] pattern, input int hold);
        int unsigned rand_word;
        int          run;
        int          spent;
        logic        pressed;

        spent   = 0;
        pressed = 1'b1;

        while (spent < hold)
        begin
            rand_word = $random (seed);

            // short closed runs, open runs long enough to meet a strobe
            if (pressed)
                run = 1 + int' (rand_word % on_run_max);
            else
                run = strobe_div + int' (rand_word % strobe_div);

            key = pressed ? ~ pattern : '1;

            for (int i = 0; i < run && spent < hold; i ++)
            begin
                @ (negedge clk);
                spent ++;
            end

            pressed = ~ pressed;
        end
    endtask

    task automatic release_keys ();
        key = '1;

        for (int i = 0; i < settle_cycles; i ++)
            @ (negedge clk);
    endtask

    //----------------------------------------
    // main sequence

    initial
    begin
        int          step;
        int          base;
        logic        done;
        logic [31:0] mode;

        seed  = 90055;
        reset = 1'b1;
        key   = '1;

        $readmemh ("bench/key_panel_golden.txt", golden);

        repeat (5) @ (negedge clk);
        reset = 1'b0;
        @ (negedge clk);

        check_outputs (32'h0, 32'h0, 32'h0, 0);

        step = 0;
        done = 1'b0;

        while (! done)
        begin
            if (step == max_steps)
                stop_with_error ("golden file has no end marker");

            base = step * step_words;
            mode = golden [base];

            if (mode === 32'hff)
            begin
                done = 1'b1;
            end
            else
            begin
                if (mode === 32'h0)
                    hold_press (golden [base + 1][n_keys - 1:0], int' (golden [base + 2]), step);
                else if (mode === 32'h1)
                    bounce_keys (golden [base + 1][n_keys - 1:0], int' (golden [base + 2]));
                else
                    stop_with_error ($sformatf ("golden file unreadable at step %0d", step));

                release_keys ();
                check_outputs (golden [base + 3], golden [base + 4], golden [base + 5], step);
                step ++;
            end
        end

        $display ("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen
(
    output logic clk
);

    // 20 ns period, first rising edge at 10 ns
    initial
    begin
        clk = 1'b0;

        forever
            #10 clk = ~ clk;
    end

endmodule

`default_nettype wire

// ==== verilog/key_panel_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_panel_top import board_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [n_keys - 1:0] key,
    output logic [n_keys - 1:0] led,
    output logic [         7:0] abcdefgh,
    output logic [         7:0] hgfedcba
);

    key_bus_if bus ();

    //----------------------------------------
    // synchronizer and strobe

    key_sampler i_key_sampler
    (
        .clk      ( clk        ),
        .reset    ( reset      ),
        .key      ( key        ),
        .bus      ( bus.source )
    );

    //----------------------------------------
    // one debouncer per key

    for (genvar i = 0; i < n_keys; i ++)
    begin : g_debouncer
        key_debouncer # (.index (i)) i_key_debouncer
        (
            .clk   ( clk        ),
            .reset ( reset      ),
            .bus   ( bus.filter )
        );
    end

    //----------------------------------------
    // leds and digit

    key_panel_encoder i_key_panel_encoder
    (
        .clk      ( clk        ),
        .reset    ( reset      ),
        .bus      ( bus.sink   ),
        .led      ( led        ),
        .abcdefgh ( abcdefgh   ),
        .hgfedcba ( hgfedcba   )
    );

endmodule

`default_nettype wire

// ==== verilog/key_panel_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_panel_encoder import board_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    key_bus_if.sink             bus,
    output logic [n_keys - 1:0] led,
    output logic [         7:0] abcdefgh,
    output logic [         7:0] hgfedcba
);

    panel_state_t        state;
    logic [w_code - 1:0] last_code;
    logic [w_code - 1:0] press_code;
    logic                any_press;
    logic                any_level;
    logic [         7:0] segments;

    //----------------------------------------
    // lowest pressed key wins

    always_comb
    begin
        press_code = '0;

        for (int i = n_keys - 1; i >= 0; i --)
        begin
            if (bus.press [i])
                press_code = w_code' (i);
        end
    end

    assign any_press = | bus.press;
    assign any_level = | bus.level;

    //----------------------------------------
    // leds, last code and state

    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            led       <= '0;
            last_code <= '0;
            state     <= panel_blank;
        end
        else if (any_press)
        begin
            led       <= led ^ bus.press;
            last_code <= press_code;
            state     <= panel_show;
        end
    end

    //----------------------------------------
    // seven-segment outputs

    always_comb
    begin
        segments = '0;

        if (state == panel_show)
        begin
            segments = hex_to_segments ({ 1'b0, last_code });

            // point lit while a key is still held down
            segments [0] = any_level;
        end
    end

    always_comb
    begin
        abcdefgh = segments;

        for (int i = 0; i < 8; i ++)
            hgfedcba [i] = segments [7 - i];
    end

    // leds move only on a press from the previous cycle
    assert property (@ (posedge clk) disable iff (reset)
        ! $stable (led) |-> $past (any_press));

endmodule

`default_nettype wire

// ==== verilog/key_debouncer.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_debouncer import board_pkg::*;
#(
    parameter int index = 0
)
(
    input  logic      clk,
    input  logic      reset,
    key_bus_if.filter bus
);

    logic                 level_q;
    logic                 press_q;
    logic [w_count - 1:0] count;

    //----------------------------------------
    // stability counter, runs on sample strobes only

    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            level_q <= 1'b0;
            press_q <= 1'b0;
            count   <= '0;
        end
        else
        begin
            press_q <= 1'b0;

            if (bus.sample)
            begin
                if (bus.synced [index] == level_q)
                begin
                    count <= '0;
                end
                else if (count == w_count' (stable_samples - 1))
                begin
                    // third strobe in a row with the new value
                    level_q <= ~ level_q;
                    press_q <= ~ level_q;
                    count   <= '0;
                end
                else
                begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    assign bus.level [index] = level_q;
    assign bus.press [index] = press_q;

    assert property (@ (posedge clk) disable iff (reset)
        bus.press [index] |-> bus.level [index] && ! $past (bus.level [index]));

endmodule

`default_nettype wire

// ==== verilog/key_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_sampler import board_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [n_keys - 1:0] key,
    key_bus_if.source           bus
);

    //----------------------------------------
    // two-stage synchronizer

    logic [n_keys - 1:0] key_meta;

    // buttons are active low on the board
    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            key_meta   <= '0;
            bus.synced <= '0;
        end
        else
        begin
            key_meta   <= ~ key;
            bus.synced <= key_meta;
        end
    end

    //----------------------------------------
    // sample strobe divider

    logic [w_strobe - 1:0] div_cnt;

    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            div_cnt    <= '0;
            bus.sample <= 1'b0;
        end
        else if (div_cnt == w_strobe' (strobe_div - 1))
        begin
            div_cnt    <= '0;
            bus.sample <= 1'b1;
        end
        else
        begin
            div_cnt    <= div_cnt + 1'b1;
            bus.sample <= 1'b0;
        end
    end

    // debouncers count strobes, so two in a row would shorten the window
    assert property (@ (posedge clk) disable iff (reset) bus.sample |=> ! bus.sample);

endmodule

`default_nettype wire

// ==== common/key_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface key_bus_if import board_pkg::*; ();

    // one-cycle strobe every strobe_div clocks
    logic                sample;

    // keys after inversion and synchronization
    logic [n_keys - 1:0] synced;

    // debounced levels and their rising-edge pulses
    logic [n_keys - 1:0] level;
    logic [n_keys - 1:0] press;

    modport source
    (
        output sample,
        output synced
    );

    modport filter
    (
        input  sample,
        input  synced,
        output level,
        output press
    );

    modport sink
    (
        input  level,
        input  press
    );

endinterface

`default_nettype wire

// ==== common/board_pkg.sv ====
`default_nettype none

package board_pkg;

    //----------------------------------------
    // widths and timing

    localparam int n_keys         = 8;
    localparam int strobe_div     = 4;
    localparam int w_strobe       = $clog2 (strobe_div);
    localparam int stable_samples = 3;
    localparam int w_count        = 2;
    localparam int w_code         = 3;

    //----------------------------------------
    // encoder state

    typedef enum logic
    {
        panel_blank = 1'b0,
        panel_show  = 1'b1
    }
    panel_state_t;

    //----------------------------------------
    // hex font, segment a in msb, h (point) in lsb

    function automatic logic [7:0] hex_to_segments (input logic [3:0] value);
        case (value)
        4'h0:    return 8'b1111_1100;
        4'h1:    return 8'b0110_0000;
        4'h2:    return 8'b1101_1010;
        4'h3:    return 8'b1111_0010;
        4'h4:    return 8'b0110_0110;
        4'h5:    return 8'b1011_0110;
        4'h6:    return 8'b1011_1110;
        4'h7:    return 8'b1110_0000;
        4'h8:    return 8'b1111_1110;
        4'h9:    return 8'b1111_0110;
        4'ha:    return 8'b1110_1110;
        4'hb:    return 8'b0011_1110;
        4'hc:    return 8'b1001_1100;
        4'hd:    return 8'b0111_1010;
        4'he:    return 8'b1001_1110;
        default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

`default_nettype wire
